/* analog_top.f */
src/analog_pkg.sv
src/ctrl_pkg.sv
src/rst_sequencer.sv
src/adc_frontend.sv
src/dac_backend.sv
src/trig_router.sv
src/exp_pin_mux.sv
src/analog_top.sv
sim/tb_analog_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the analog_top testbench with Verilator

LOG=sim.log

verilator --binary --timing -f analog_top.f --top-module tb_analog_top \
  --Mdir obj_dir -o tb_analog_top
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_analog_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim/tb_analog_top.sv */
// analog top testbench

module tb_analog_top;
  timeunit 1ns;
  timeprecision 1ps;

  logic adc_clk;
  logic rst_n_i;
  logic pll_locked_i;
  logic core_rstn_o;
  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_W-1:0] adc_dat_i;
  analog_pkg::adc_sample_t [analog_pkg::N_CH-1:0] adc_dat_o;
  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] asg_dat_i;
  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] pid_dat_i;
  logic [1:0] digital_loop_i;
  analog_pkg::dac_code_t dac_dat_a_o;
  analog_pkg::dac_code_t dac_dat_b_o;
  logic [2:0] daisy_mode_i;
  logic [ctrl_pkg::PAR_W-1:0] par_dat_i;
  logic [ctrl_pkg::PAR_W-1:0] par_dat_o;
  logic daisy_rx_rdy_i, scope_trig_i, asg_trig_i;
  logic trig_ext_o, par_dv_o;
  logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_i, exp_n_dat_i, hk_p_dat_i, hk_n_dat_i;
  logic [ctrl_pkg::EXP_W-1:0] hk_p_dir_i, hk_n_dir_i;
  logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_o, exp_n_dat_o, exp_p_dir_o, exp_n_dir_o;
  logic can_on_i, can0_tx_i, can1_tx_i;
  logic can0_rx_o, can1_rx_o;

  logic [31:0] seed = 32'h111d_f126;
  int test_errs;     // errors in running test
  int total_errs;
  int tests_run;
  int tests_failed;

  analog_top uut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 25 MHz
  end

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // mostly random, sometimes full scale so the sum overflows
  function automatic analog_pkg::dac_code_t pick_code(input logic [31:0] r, input bit ext);
    if (ext && r[17:16] == 2'd0) return 14'h1fff;  // +8191
    if (ext && r[17:16] == 2'd1) return 14'h2000;  // -8192
    return analog_pkg::dac_code_t'(r);
  endfunction

  function automatic analog_pkg::adc_sample_t adc_model(input logic [15:0] raw);
    return raw ^ 16'h7fff;  // offset code, msb stays
  endfunction

  function automatic analog_pkg::dac_code_t sat_model(input analog_pkg::dac_code_t a,
                                                      input analog_pkg::dac_code_t p);
    int sum;
    sum = int'($signed(a)) + int'($signed(p));
    if (sum > 8191) sum = 8191;
    else if (sum < -8192) sum = -8192;
    return analog_pkg::dac_code_t'(sum);
  endfunction

  function automatic analog_pkg::dac_code_t dac_model(input analog_pkg::dac_code_t s);
    return s ^ 14'h1fff;  // back to negative slope
  endfunction

  ////////////////////////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////////////////////////

  task automatic adc_compare(input string name, input analog_pkg::adc_sample_t exp_v,
                             input analog_pkg::adc_sample_t act);
    if (act !== exp_v) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic dac_compare(input string name, input analog_pkg::dac_code_t exp_v,
                             input analog_pkg::dac_code_t act);
    if (act !== exp_v) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic bit_compare(input string name, input logic exp_v, input logic act);
    if (act !== exp_v) begin
      $display("ERROR %s: expected %b, actual %b", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic par_compare(input string name, input logic [ctrl_pkg::PAR_W-1:0] exp_v,
                             input logic [ctrl_pkg::PAR_W-1:0] act);
    if (act !== exp_v) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic pins_compare(input string name, input logic [ctrl_pkg::EXP_W-1:0] exp_v,
                              input logic [ctrl_pkg::EXP_W-1:0] act);
    if (act !== exp_v) begin
      $display("ERROR %s: expected %h, actual %h", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic count_compare(input string name, input int exp_v, input int act);
    if (act != exp_v) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp_v, act);
      test_errs++;
    end
  endtask

  task automatic test_end(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    total_errs += test_errs;
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // reset sequence
  ////////////////////////////////////////////////////////////

  task automatic wait_core_low(input int limit, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge adc_clk);
      seen = !core_rstn_o;
    end
    if (!seen) begin
      $display("core reset never went low within %0d cycles of pll lock", limit);
      test_errs++;
    end
  endtask

  // registered outputs held at zero by the core reset
  task automatic check_cleared(input string name);
    adc_compare(name, '0, adc_dat_o[0]);
    adc_compare(name, '0, adc_dat_o[1]);
    dac_compare(name, '0, dac_dat_a_o);
    dac_compare(name, '0, dac_dat_b_o);
  endtask

  // low cycles, starting with the current sample
  task automatic count_low(input string name, input int limit, output int n);
    n = 0;
    while (!core_rstn_o && n < limit) begin
      if (n > 0) check_cleared(name);  // clear lands one edge after core reset
      n++;
      @(negedge adc_clk);
    end
    if (!core_rstn_o) begin
      $display("core reset still low after %0d cycles", limit);
      test_errs++;
    end
  endtask

  task automatic reset_seq_run(input string name);
    bit seen;
    int n;
    @(negedge adc_clk);
    pll_locked_i = 1'b1;
    wait_core_low(8, seen);
    if (seen) begin
      count_low(name, ctrl_pkg::RST_LEN + 8, n);
      count_compare(name, ctrl_pkg::RST_LEN, n);
    end
    // re-arm, then lose lock mid count
    @(negedge adc_clk);
    pll_locked_i = 1'b0;
    @(negedge adc_clk);
    pll_locked_i = 1'b1;
    wait_core_low(8, seen);
    if (seen) begin
      repeat (10) @(negedge adc_clk);
      pll_locked_i = 1'b0;
      count_low(name, 8, n);
      count_compare(name, 2, n);  // count clears, then output one cycle later
    end
    test_end(name);
  endtask

  ////////////////////////////////////////////////////////////
  // converter datapath
  ////////////////////////////////////////////////////////////

  task automatic datapath_run(input string name, input logic [1:0] loop, input int n,
                              input bit ext);
    analog_pkg::adc_sample_t exp_adc [analog_pkg::N_CH];
    analog_pkg::dac_code_t   exp_dac [analog_pkg::N_CH];
    analog_pkg::adc_sample_t adc_q [analog_pkg::N_CH];  // ADC register at next edge
    analog_pkg::dac_code_t   s;
    for (int i = 0; i < n; i++) begin
      @(negedge adc_clk);
      if (i >= 2) begin  // model state known from here on
        adc_compare(name, exp_adc[0], adc_dat_o[0]);
        adc_compare(name, exp_adc[1], adc_dat_o[1]);
        dac_compare(name, exp_dac[0], dac_dat_a_o);
        dac_compare(name, exp_dac[1], dac_dat_b_o);
      end
      adc_q = exp_adc;
      digital_loop_i = loop;
      for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
        adc_dat_i[ch] = 16'(next_rand());
        asg_dat_i[ch] = pick_code(next_rand(), ext);
        pid_dat_i[ch] = pick_code(next_rand(), ext);
        s = sat_model(asg_dat_i[ch], pid_dat_i[ch]);
        exp_adc[ch] = loop[0] ? analog_pkg::adc_sample_t'({2'b00, s}) : adc_model(adc_dat_i[ch]);
        // ADC loopback drops the two lsbs
        exp_dac[ch] = loop[1] ? dac_model(analog_pkg::dac_code_t'(adc_q[ch] >> 2)) : dac_model(s);
      end
    end
    test_end(name);
  endtask

  ////////////////////////////////////////////////////////////
  // triggers and expansion pins
  ////////////////////////////////////////////////////////////

  task automatic ctrl_randomize();
    logic [31:0] r;
    r = next_rand();
    daisy_mode_i   = r[2:0];
    daisy_rx_rdy_i = r[3];
    scope_trig_i   = r[4];
    asg_trig_i     = r[5];
    can_on_i       = r[6];
    can0_tx_i      = r[7];
    can1_tx_i      = r[8];
    par_dat_i      = (r[10:9] == 2'b00) ? '0 : 16'(next_rand());  // empty word now and then
    r = next_rand();
    exp_p_dat_i = ctrl_pkg::EXP_W'(r);
    exp_n_dat_i = ctrl_pkg::EXP_W'(r >> ctrl_pkg::EXP_W);
    r = next_rand();
    hk_p_dat_i = ctrl_pkg::EXP_W'(r);
    hk_n_dat_i = ctrl_pkg::EXP_W'(r >> ctrl_pkg::EXP_W);
    r = next_rand();
    hk_p_dir_i = ctrl_pkg::EXP_W'(r);
    hk_n_dir_i = ctrl_pkg::EXP_W'(r >> ctrl_pkg::EXP_W);
  endtask

  task automatic trig_run(input string name, input int n);
    logic sync;
    logic sel;
    for (int i = 0; i < n; i++) begin
      @(negedge adc_clk);
      ctrl_randomize();
      sync = daisy_mode_i[ctrl_pkg::MODE_SYNC];
      sel  = daisy_mode_i[ctrl_pkg::MODE_ASG] ? asg_trig_i : scope_trig_i;
      @(posedge adc_clk);  // comb paths settled
      bit_compare(name, exp_n_dat_i[ctrl_pkg::PIN_TRIG] & ~(sync & (par_dat_i != '0)),
                  trig_ext_o);
      par_compare(name, sync ? {ctrl_pkg::PAR_W{sel}} : ctrl_pkg::DAISY_IDLE, par_dat_o);
      bit_compare(name, sync ? 1'b0 : daisy_rx_rdy_i, par_dv_o);
    end
    test_end(name);
  endtask

  task automatic pins_run(input string name, input int n);
    logic [ctrl_pkg::EXP_W-1:0] n_dat;
    logic [ctrl_pkg::EXP_W-1:0] n_dir;
    logic sel;
    for (int i = 0; i < n; i++) begin
      @(negedge adc_clk);
      ctrl_randomize();
      sel   = daisy_mode_i[ctrl_pkg::MODE_ASG] ? asg_trig_i : scope_trig_i;
      n_dat = hk_n_dat_i;
      n_dir = hk_n_dir_i;
      if (daisy_mode_i[ctrl_pkg::MODE_FLAG]) begin
        n_dat[ctrl_pkg::PIN_TRIG] = sel;  // trigger out
        n_dir[ctrl_pkg::PIN_TRIG] = 1'b1;
      end
      if (can_on_i) begin
        n_dat[ctrl_pkg::PIN_CAN0] = can0_tx_i;
        n_dat[ctrl_pkg::PIN_CAN1] = can1_tx_i;
        n_dir[ctrl_pkg::PIN_CAN0] = 1'b1;
        n_dir[ctrl_pkg::PIN_CAN1] = 1'b1;
      end
      @(posedge adc_clk);
      pins_compare(name, hk_p_dat_i, exp_p_dat_o);
      pins_compare(name, hk_p_dir_i, exp_p_dir_o);
      pins_compare(name, n_dat, exp_n_dat_o);
      pins_compare(name, n_dir, exp_n_dir_o);
      bit_compare(name, can_on_i & exp_p_dat_i[ctrl_pkg::PIN_CAN0], can0_rx_o);
      bit_compare(name, can_on_i & exp_p_dat_i[ctrl_pkg::PIN_CAN1], can1_rx_o);
    end
    test_end(name);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n_i        = 1'b0;
    pll_locked_i   = 1'b0;
    adc_dat_i      = '0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    digital_loop_i = 2'b00;
    daisy_mode_i   = 3'b000;
    par_dat_i      = '0;
    daisy_rx_rdy_i = 1'b0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;
    exp_p_dat_i    = '0;
    exp_n_dat_i    = '0;
    hk_p_dat_i     = '0;
    hk_n_dat_i     = '0;
    hk_p_dir_i     = '0;
    hk_n_dir_i     = '0;
    can_on_i       = 1'b0;
    can0_tx_i      = 1'b0;
    can1_tx_i      = 1'b0;
    test_errs      = 0;
    total_errs     = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (16) @(negedge adc_clk);
    rst_n_i = 1'b1;

    reset_seq_run("rst_seq");  // leaves lock low, core out of reset
    datapath_run("adc_conv", 2'b00, 200, 1'b0);
    datapath_run("dac_sat", 2'b00, 200, 1'b1);
    datapath_run("loop_dac_to_adc", 2'b01, 100, 1'b1);
    datapath_run("loop_adc_to_dac", 2'b10, 100, 1'b0);
    datapath_run("loop_both", 2'b11, 100, 1'b1);
    trig_run("trig_route", 200);
    pins_run("exp_pins", 200);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src/analog_top.sv */
// analog datapath and connector glue

module analog_top (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic pll_locked_i,
  output logic core_rstn_o,
  // ADC
  input  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_W-1:0] adc_dat_i,
  output analog_pkg::adc_sample_t [analog_pkg::N_CH-1:0] adc_dat_o,
  // DAC
  input  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] asg_dat_i,
  input  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] pid_dat_i,
  input  logic [1:0] digital_loop_i,  // [0] DAC to ADC, [1] ADC to DAC
  output analog_pkg::dac_code_t dac_dat_a_o,
  output analog_pkg::dac_code_t dac_dat_b_o,
  // triggers and daisy chain
  input  logic [2:0]                 daisy_mode_i,
  input  logic [ctrl_pkg::PAR_W-1:0] par_dat_i,
  input  logic                       daisy_rx_rdy_i,
  input  logic                       scope_trig_i,
  input  logic                       asg_trig_i,
  output logic                       trig_ext_o,
  output logic [ctrl_pkg::PAR_W-1:0] par_dat_o,
  output logic                       par_dv_o,
  // expansion connector
  input  logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] exp_n_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_p_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_n_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_p_dir_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_n_dir_i,
  input  logic                       can_on_i,
  input  logic                       can0_tx_i,
  input  logic                       can1_tx_i,
  output logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_n_dat_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_p_dir_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_n_dir_o,
  output logic                       can0_rx_o,
  output logic                       can1_rx_o
);

  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] sat_code;  // DAC codes before output reg
  logic trig_sel;

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////

  rst_sequencer i_rst (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .core_rstn_o  (core_rstn_o)
  );

  ////////////////////////////////////////////////////////////
  // converters
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .core_rstn_i (core_rstn_o),
    .loop_i      (digital_loop_i[0]),
    .adc_raw_i   (adc_dat_i),
    .sat_code_i  (sat_code),
    .adc_dat_o   (adc_dat_o)   // also feeds DAC loopback
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .core_rstn_i (core_rstn_o),
    .loop_i      (digital_loop_i[1]),
    .asg_dat_i   (asg_dat_i),
    .pid_dat_i   (pid_dat_i),
    .adc_dat_i   (adc_dat_o),
    .sat_code_o  (sat_code),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  ////////////////////////////////////////////////////////////
  // triggers and connector
  ////////////////////////////////////////////////////////////

  trig_router i_trig (
    .daisy_mode_i   (daisy_mode_i),
    .par_dat_i      (par_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .gpio_trig_i    (exp_n_dat_i[ctrl_pkg::PIN_TRIG]),  // n side pin 0
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .trig_ext_o     (trig_ext_o),
    .trig_sel_o     (trig_sel),
    .par_dv_o       (par_dv_o),
    .par_dat_o      (par_dat_o)
  );

  exp_pin_mux i_exp (
    .exp_p_dat_i  (exp_p_dat_i),
    .exp_n_dat_i  (exp_n_dat_i),
    .hk_p_dat_i   (hk_p_dat_i),
    .hk_n_dat_i   (hk_n_dat_i),
    .hk_p_dir_i   (hk_p_dir_i),
    .hk_n_dir_i   (hk_n_dir_i),
    .can_on_i     (can_on_i),
    .can0_tx_i    (can0_tx_i),
    .can1_tx_i    (can1_tx_i),
    .daisy_flag_i (daisy_mode_i[ctrl_pkg::MODE_FLAG]),
    .trig_sel_i   (trig_sel),
    .exp_p_dat_o  (exp_p_dat_o),
    .exp_n_dat_o  (exp_n_dat_o),
    .exp_p_dir_o  (exp_p_dir_o),
    .exp_n_dir_o  (exp_n_dir_o),
    .can0_rx_o    (can0_rx_o),
    .can1_rx_o    (can1_rx_o)
  );

endmodule

/* src/exp_pin_mux.sv */
// expansion connector alternate functions

module exp_pin_mux (
  input  logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_i,  // pin readback
  input  logic [ctrl_pkg::EXP_W-1:0] exp_n_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_p_dat_i,   // housekeeping gpio
  input  logic [ctrl_pkg::EXP_W-1:0] hk_n_dat_i,
  input  logic [ctrl_pkg::EXP_W-1:0] hk_p_dir_i,   // 1 = output
  input  logic [ctrl_pkg::EXP_W-1:0] hk_n_dir_i,
  input  logic                       can_on_i,
  input  logic                       can0_tx_i,
  input  logic                       can1_tx_i,
  input  logic                       daisy_flag_i,
  input  logic                       trig_sel_i,
  output logic [ctrl_pkg::EXP_W-1:0] exp_p_dat_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_n_dat_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_p_dir_o,
  output logic [ctrl_pkg::EXP_W-1:0] exp_n_dir_o,
  output logic                       can0_rx_o,
  output logic                       can1_rx_o
);

  logic [ctrl_pkg::EXP_W-1:0] n_alt;      // alternate function on
  logic [ctrl_pkg::EXP_W-1:0] n_alt_dat;  // alternate function data

  ////////////////////////////////////////////////////////////
  // p side, housekeeping only
  ////////////////////////////////////////////////////////////

  assign exp_p_dat_o = hk_p_dat_i;
  assign exp_p_dir_o = hk_p_dir_i;

  ////////////////////////////////////////////////////////////
  // n side
  ////////////////////////////////////////////////////////////

  always_comb begin
    n_alt     = '0;
    n_alt_dat = '0;
    n_alt[ctrl_pkg::PIN_TRIG]     = daisy_flag_i;  // trigger out
    n_alt_dat[ctrl_pkg::PIN_TRIG] = trig_sel_i;
    n_alt[ctrl_pkg::PIN_CAN0]     = can_on_i;
    n_alt_dat[ctrl_pkg::PIN_CAN0] = can0_tx_i;
    n_alt[ctrl_pkg::PIN_CAN1]     = can_on_i;
    n_alt_dat[ctrl_pkg::PIN_CAN1] = can1_tx_i;
  end

  // alternate pins are always outputs
  assign exp_n_dat_o = (n_alt & n_alt_dat) | (~n_alt & hk_n_dat_i);
  assign exp_n_dir_o = n_alt | hk_n_dir_i;

  // CAN receive from p pins, quiet when CAN is off
  assign can0_rx_o = can_on_i & exp_p_dat_i[ctrl_pkg::PIN_CAN0];
  assign can1_rx_o = can_on_i & exp_p_dat_i[ctrl_pkg::PIN_CAN1];

endmodule

/* src/trig_router.sv */
// trigger routing and daisy transmit

module trig_router (
  input  logic [2:0]                  daisy_mode_i,
  input  logic [ctrl_pkg::PAR_W-1:0]  par_dat_i,       // received daisy word
  input  logic                        daisy_rx_rdy_i,
  input  logic                        gpio_trig_i,     // expansion trigger pin
  input  logic                        scope_trig_i,
  input  logic                        asg_trig_i,
  output logic                        trig_ext_o,
  output logic                        trig_sel_o,      // trigger out, to pin mux
  output logic                        par_dv_o,
  output logic [ctrl_pkg::PAR_W-1:0]  par_dat_o        // word to daisy transmitter
);

  logic sync_mode;
  logic daisy_trig;

  assign sync_mode  = daisy_mode_i[ctrl_pkg::MODE_SYNC];
  assign daisy_trig = |par_dat_i;  // any bit set counts

  ////////////////////////////////////////////////////////////
  // triggers
  ////////////////////////////////////////////////////////////

  // pin trigger blocked while a daisy trigger arrives in sync mode
  assign trig_ext_o = gpio_trig_i & ~(sync_mode & daisy_trig);

  assign trig_sel_o = daisy_mode_i[ctrl_pkg::MODE_ASG] ? asg_trig_i : scope_trig_i;

  ////////////////////////////////////////////////////////////
  // daisy transmit
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (sync_mode) begin
      par_dat_o = {ctrl_pkg::PAR_W{trig_sel_o}};  // trigger on every bit
      par_dv_o  = 1'b0;
    end else begin
      par_dat_o = ctrl_pkg::DAISY_IDLE;  // test pattern
      par_dv_o  = daisy_rx_rdy_i;
    end
  end

endmodule

/* src/dac_backend.sv */
// DAC sum, saturation and code conversion

module dac_backend (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic core_rstn_i,  // sync clear of output regs
  input  logic loop_i,       // send ADC samples to DAC
  input  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] asg_dat_i,
  input  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] pid_dat_i,
  input  analog_pkg::adc_sample_t [analog_pkg::N_CH-1:0] adc_dat_i,
  output analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] sat_code_o,  // comb, for ADC loopback
  output analog_pkg::dac_code_t dac_dat_a_o,
  output analog_pkg::dac_code_t dac_dat_b_o
);

  localparam int ADC_W = analog_pkg::ADC_W;
  localparam int DAC_W = analog_pkg::DAC_W;
  localparam int SUM_W = analog_pkg::SUM_W;

  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] code_nxt;
  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] code_q;

  ////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic signed [SUM_W-1:0] sum;
    logic [DAC_W-1:0]        sat;
    for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
      sum = $signed(asg_dat_i[ch]) + $signed(pid_dat_i[ch]);  // sign extended
      // top two bits differ, so out of 14-bit range
      if (sum[SUM_W-1] ^ sum[SUM_W-2]) begin
        sat = {sum[SUM_W-1], {(DAC_W-1){~sum[SUM_W-1]}}};  // clamp to limit of sign
      end else begin
        sat = sum[DAC_W-1:0];
      end
      sat_code_o[ch] = sat;

      if (loop_i) begin
        // ADC sample back out, drop 2 lsbs
        code_nxt[ch] = {adc_dat_i[ch][ADC_W-1], ~adc_dat_i[ch][ADC_W-2 -: DAC_W-1]};
      end else begin
        code_nxt[ch] = {sat[DAC_W-1], ~sat[DAC_W-2:0]};  // to negative slope
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      code_q <= '0;
    end else if (!core_rstn_i) begin
      code_q <= '0;
    end else begin
      code_q <= code_nxt;
    end
  end

  assign dac_dat_a_o = code_q[0];  // channel a
  assign dac_dat_b_o = code_q[1];  // channel b

endmodule

/* src/adc_frontend.sv */
// ADC code conversion

module adc_frontend (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic core_rstn_i,  // sync clear of output regs
  input  logic loop_i,       // take DAC codes instead of ADC
  input  logic [analog_pkg::N_CH-1:0][analog_pkg::ADC_W-1:0] adc_raw_i,
  input  analog_pkg::dac_code_t [analog_pkg::N_CH-1:0] sat_code_i,
  output analog_pkg::adc_sample_t [analog_pkg::N_CH-1:0] adc_dat_o
);

  localparam int ADC_W = analog_pkg::ADC_W;
  localparam int PAD_W = analog_pkg::ADC_W - analog_pkg::DAC_W;

  analog_pkg::adc_sample_t [analog_pkg::N_CH-1:0] adc_nxt;

  ////////////////////////////////////////////////////////////
  // conversion
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < analog_pkg::N_CH; ch++) begin
      if (loop_i) begin
        adc_nxt[ch] = {{PAD_W{1'b0}}, sat_code_i[ch]};  // digital loopback
      end else begin
        // negative slope to two's complement
        adc_nxt[ch] = {adc_raw_i[ch][ADC_W-1], ~adc_raw_i[ch][ADC_W-2:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else if (!core_rstn_i) begin
      adc_dat_o <= '0;  // held during core reset
    end else begin
      adc_dat_o <= adc_nxt;
    end
  end

endmodule

/* src/rst_sequencer.sv */
// core reset after pll lock

module rst_sequencer (
  input  logic adc_clk,
  input  logic rst_n_i,
  input  logic pll_locked_i,
  output logic core_rstn_o
);

  // counter has to reach RST_LEN itself
  localparam int CNT_W = $clog2(ctrl_pkg::RST_LEN + 1);

  logic             locked_q;  // lock flag, one cycle late
  logic             lock_rise;
  logic [CNT_W-1:0] cnt;

  assign lock_rise = pll_locked_i & ~locked_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      cnt      <= '0;
    end else begin
      locked_q <= pll_locked_i;
      if (!pll_locked_i) begin
        cnt <= '0;  // lock lost, abort sequence
      end else if (lock_rise || (cnt != '0)) begin
        // runs 1..RST_LEN then wraps to idle
        cnt <= (cnt == CNT_W'(ctrl_pkg::RST_LEN)) ? '0 : cnt + 1'b1;
      end
    end
  end

  // low while counting, registered
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) core_rstn_o <= 1'b0;
    else          core_rstn_o <= (cnt == '0);
  end

endmodule

/* src/ctrl_pkg.sv */
// control and connector constants

package ctrl_pkg;

  // reset sequence
  localparam int RST_LEN = 64;  // core reset cycles after pll lock

  // expansion connector, per side
  localparam int EXP_W = 11;

  // daisy parallel word
  localparam int PAR_W = 16;
  localparam logic [PAR_W-1:0] DAISY_IDLE = 16'h1234;  // sent when not in sync mode

  ////////////////////////////////////////////////////////////
  // daisy_mode bits
  ////////////////////////////////////////////////////////////

  localparam int MODE_SYNC = 0;  // trigger sync over daisy chain
  localparam int MODE_FLAG = 1;  // trigger out on expansion pin
  localparam int MODE_ASG  = 2;  // generator trigger instead of scope

  ////////////////////////////////////////////////////////////
  // alternate function pins, n side
  ////////////////////////////////////////////////////////////

  localparam int PIN_TRIG = 0;
  localparam int PIN_CAN1 = 6;
  localparam int PIN_CAN0 = 7;

endpackage

/* src/analog_pkg.sv */
// converter sample definitions

package analog_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int N_CH  = 2;   // ADC and DAC channels
  localparam int ADC_W = 16;  // ADC sample, lowest 2 bits spare on 14-bit parts
  localparam int DAC_W = 14;  // DAC code
  localparam int SUM_W = DAC_W + 1;  // generator + controller, one guard bit

  ////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////

  // two's complement after front end conversion
  typedef logic signed [ADC_W-1:0] adc_sample_t;

  // 14-bit code
  // signed on the generator and controller side,
  // negative-slope offset code on the DAC pins
  typedef logic [DAC_W-1:0] dac_code_t;

endpackage
